//--- sim.f
+incdir+include
src/sd_card_pkg.sv
src/sck_edge_detect.sv
src/sd_cmd_receiver.sv
src/sd_card_fsm.sv
src/sd_read_streamer.sv
src/sd_spi_card.sv
verif/sd_spi_card_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f \
    --top-module sd_spi_card_tb \
    --Mdir obj_dir \
    -o sd_spi_card_sim

./obj_dir/sd_spi_card_sim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi
echo "simulation passed"

//--- verif/sd_spi_card_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "sd_card_config.svh"

module sd_spi_card_tb;
    import sd_card_pkg::*;

    localparam int BLK       = `SD_BLOCK_SIZE;
    localparam int BYTE_CLKS = 64;   // 8 sck periods of 8 clk

    typedef struct packed {
        sd_cmd_idx_t idx;
        sd_arg_t     arg;
        logic        bad_crc;
        sd_r1_t      r1;
        logic        has_ocr;
        sd_arg_t     ocr;
        int          blocks;   // blocks to read after the response
        sd_arg_t     blk;      // expected first block number
    } step_t;

    logic   clk;
    logic   i_rst_n;
    logic   i_sck;
    logic   i_csn;
    logic   i_mosi;
    logic   o_miso;
    step_t  steps[$];
    string  names[$];
    int     budget_bytes = 0;
    int     timeout_cycles = 0;
    int     cycle_cnt = 0;

    sd_spi_card dut (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_sck   (i_sck),
        .i_csn   (i_csn),
        .i_mosi  (i_mosi),
        .o_miso  (o_miso)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_cycles > 0 && cycle_cnt >= timeout_cycles) begin
            $display("timeout after %0d cycles, the card stopped answering", cycle_cnt);
            $display("SOME TESTS FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    // long division by x^7 + x^3 + 1
    function automatic logic [6:0] calc_crc7(input logic [39:0] msg);
        logic [46:0] rem;
        rem = {msg, 7'd0};
        for (int i = 46; i >= 7; i--) begin
            if (rem[i]) begin
                rem[i -: 8] = rem[i -: 8] ^ 8'h89;
            end
        end
        return rem[6:0];
    endfunction

    function automatic logic [15:0] crc16_update(input logic [15:0] crc, input logic [7:0] d);
        logic [15:0] c;
        c = crc ^ {d, 8'h00};
        for (int k = 0; k < 8; k++) begin
            c = c[15] ? ({c[14:0], 1'b0} ^ 16'h1021) : {c[14:0], 1'b0};
        end
        return c;
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("ERR %0s %0s: expected 0x%0h, actual 0x%0h", name, what, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // mode 0, mosi set while sck low, miso read mid high phase
    task automatic xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            i_mosi = tx[i];
            repeat (4) @(negedge clk);
            i_sck = 1'b1;
            repeat (2) @(negedge clk);
            rx[i] = o_miso;
            repeat (2) @(negedge clk);
            i_sck = 1'b0;   // card shifts on this edge
        end
    endtask

    task automatic send_cmd(input sd_cmd_idx_t idx, input sd_arg_t arg, input logic bad_crc);
        logic [39:0] head;
        logic [6:0]  crc;
        logic [47:0] frame;
        logic [7:0]  rx;
        head  = {2'b01, idx, arg};
        crc   = calc_crc7(head);
        crc   = bad_crc ? ~crc : crc;
        frame = {head, crc, 1'b1};
        for (int b = 5; b >= 0; b--) begin
            xfer_byte(frame[b*8 +: 8], rx);
        end
    endtask

    // clocks 0xff until the card sends something else
    task automatic scan_first_byte(input string name, input string what,
                                   output logic [7:0] first);
        logic [7:0] rx;
        int         tries;
        rx    = 8'hFF;
        tries = 0;
        while (rx == 8'hFF && tries < 8) begin
            xfer_byte(8'hFF, rx);
            tries++;
        end
        assert (rx != 8'hFF) else begin
            $display("%0s: only 0xFF seen on miso while waiting for the %0s", name, what);
            $display("SOME TESTS FAILED");
            $fatal(1, "missing byte");
        end
        first = rx;
    endtask

    task automatic read_block(input string name, input sd_arg_t blk);
        logic [7:0]  rx;
        logic [7:0]  hi;
        logic [7:0]  exp_byte;
        logic [15:0] crc;
        scan_first_byte(name, "token", rx);
        check_value(name, "token", 32'hFE, 32'(rx));
        crc = 16'h0000;
        for (int i = 0; i < BLK; i++) begin
            exp_byte = 8'(blk + sd_arg_t'(i));   // low byte of address plus index
            xfer_byte(8'hFF, rx);
            check_value(name, "data", 32'(exp_byte), 32'(rx));
            crc = crc16_update(crc, exp_byte);
        end
        xfer_byte(8'hFF, hi);
        xfer_byte(8'hFF, rx);
        check_value(name, "crc16", 32'(crc), 32'({hi, rx}));
    endtask

    task automatic add_step(input string name, input sd_cmd_idx_t idx, input sd_arg_t arg,
                            input logic bad_crc, input sd_r1_t r1, input logic has_ocr,
                            input sd_arg_t ocr, input int blocks, input sd_arg_t blk);
        steps.push_back('{idx, arg, bad_crc, r1, has_ocr, ocr, blocks, blk});
        names.push_back(name);
        budget_bytes += 18 + blocks * (BLK + 10);   // cmd, scan, ocr; scan, token, crc
    endtask

    task automatic build_table();
        sd_arg_t hcs_blk;
        sd_arg_t hcs_blk2;
        sd_arg_t std_blk;
        sd_arg_t std_off;
        sd_arg_t acmd_hcs;
        sd_arg_t acmd_std;
        hcs_blk  = $urandom;
        hcs_blk2 = $urandom;
        std_blk  = $urandom % 32'h0080_0000;   // keeps the byte address in 32 bits
        std_off  = $urandom % sd_arg_t'(BLK);
        acmd_hcs = $urandom | 32'h4000_0000;
        acmd_std = $urandom & ~32'h4000_0000;
        add_step("cmd0_reset",    CMD_GO_IDLE,       '0,       0, 8'h01, 0, '0, 0, '0);
        add_step("cmd8_check",    CMD_SEND_IF_COND,  32'h1AA,  0, 8'h01, 0, '0, 0, '0);
        add_step("cmd58_idle",    CMD_READ_OCR,      '0,       0, 8'h01, 1, 32'h00FF8000, 0, '0);
        add_step("cmd0_badcrc",   CMD_GO_IDLE,       '0,       1, 8'h09, 0, '0, 0, '0);
        add_step("cmd17_illegal", 6'd17,             '0,       0, 8'h05, 0, '0, 0, '0);
        add_step("cmd18_idle",    CMD_READ_MULTI,    '0,       0, 8'h05, 0, '0, 0, '0);
        add_step("acmd41_noapp",  ACMD_SEND_OP_COND, acmd_hcs, 0, 8'h01, 0, '0, 0, '0);
        add_step("cmd58_still",   CMD_READ_OCR,      '0,       0, 8'h01, 1, 32'h00FF8000, 0, '0);
        add_step("cmd55_hcs",     CMD_APP_CMD,       '0,       0, 8'h01, 0, '0, 0, '0);
        add_step("acmd41_hcs",    ACMD_SEND_OP_COND, acmd_hcs, 0, 8'h01, 0, '0, 0, '0);
        add_step("cmd58_ready",   CMD_READ_OCR,      '0,       0, 8'h00, 1, 32'hC0FF8000, 0, '0);
        add_step("cmd18_hcs",     CMD_READ_MULTI,    hcs_blk,  0, 8'h00, 0, '0, 2, hcs_blk);
        add_step("cmd12_stop",    CMD_STOP_TRAN,     '0,       0, 8'h00, 0, '0, 0, '0);
        add_step("cmd18_again",   CMD_READ_MULTI,    hcs_blk2, 0, 8'h00, 0, '0, 1, hcs_blk2);
        add_step("cmd12_again",   CMD_STOP_TRAN,     '0,       0, 8'h00, 0, '0, 0, '0);
        add_step("cmd8_badcrc",   CMD_SEND_IF_COND,  32'h1AA,  1, 8'h08, 0, '0, 0, '0);
        // second pass with a standard capacity host
        add_step("cmd0_std",      CMD_GO_IDLE,       '0,       0, 8'h01, 0, '0, 0, '0);
        add_step("cmd55_std",     CMD_APP_CMD,       '0,       0, 8'h01, 0, '0, 0, '0);
        add_step("acmd41_std",    ACMD_SEND_OP_COND, acmd_std, 0, 8'h01, 0, '0, 0, '0);
        add_step("cmd58_std",     CMD_READ_OCR,      '0,       0, 8'h00, 1, 32'h80FF8000, 0, '0);
        add_step("cmd18_std",     CMD_READ_MULTI,    std_blk * sd_arg_t'(BLK) + std_off,
                 0, 8'h00, 0, '0, 1, std_blk);
        add_step("cmd12_std",     CMD_STOP_TRAN,     '0,       0, 8'h00, 0, '0, 0, '0);
        timeout_cycles = (budget_bytes + 2) * BYTE_CLKS * 3 / 2 + 10;
    endtask

    initial begin
        logic [7:0]  r1;
        logic [7:0]  rx;
        logic [15:0] crc;
        sd_arg_t     ocr;
        i_rst_n = 1'b0;
        i_sck   = 1'b0;
        i_csn   = 1'b1;
        i_mosi  = 1'b1;
        void'($urandom(14256));
        build_table();

        // reference values from the SD spec
        check_value("crc_ref", "crc7 cmd0", 32'h4A, 32'(calc_crc7(40'h40_0000_0000)));
        check_value("crc_ref", "crc7 cmd8", 32'h43, 32'(calc_crc7(40'h48_0000_01AA)));
        crc = 16'h0000;
        for (int i = 0; i < 512; i++) begin
            crc = crc16_update(crc, 8'hFF);
        end
        check_value("crc_ref", "crc16 ff block", 32'h7FA1, 32'(crc));

        repeat (2) @(negedge clk);
        i_rst_n = 1'b1;
        repeat (2) xfer_byte(8'hFF, rx);    // wake-up clocks with csn high
        i_csn = 1'b0;

        for (int s = 0; s < steps.size(); s++) begin
            send_cmd(steps[s].idx, steps[s].arg, steps[s].bad_crc);
            scan_first_byte(names[s], "R1", r1);
            check_value(names[s], "R1", 32'(steps[s].r1), 32'(r1));
            if (steps[s].has_ocr) begin
                ocr = '0;
                repeat (4) begin
                    xfer_byte(8'hFF, rx);
                    ocr = {ocr[23:0], rx};
                end
                check_value(names[s], "OCR", steps[s].ocr, ocr);
            end
            for (int b = 0; b < steps[s].blocks; b++) begin
                read_block(names[s], steps[s].blk + sd_arg_t'(b));   // consecutive blocks
            end
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/sd_spi_card.sv
`timescale 1ns/10ps
`default_nettype none

module sd_spi_card (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_sck,
    input  logic i_csn,
    input  logic i_mosi,
    output logic o_miso
);
    import sd_card_pkg::*;

    logic     sck_rise;
    logic     sck_fall;
    logic     csn_sync;
    logic     mosi_sync;
    sd_cmd_t  cmd;
    logic     cmd_valid;
    sd_resp_t resp;
    logic     resp_valid;
    logic     rd_start;
    sd_arg_t  rd_addr;
    logic     rd_stop;

    sck_edge_detect u_edge (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_sck      (i_sck),
        .i_csn      (i_csn),
        .i_mosi     (i_mosi),
        .o_sck_rise (sck_rise),
        .o_sck_fall (sck_fall),
        .o_csn      (csn_sync),
        .o_mosi     (mosi_sync)
    );

    sd_cmd_receiver u_rx (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_sck_rise  (sck_rise),
        .i_csn       (csn_sync),
        .i_mosi      (mosi_sync),
        .o_cmd       (cmd),
        .o_cmd_valid (cmd_valid)
    );

    sd_card_fsm u_fsm (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_cmd        (cmd),
        .i_cmd_valid  (cmd_valid),
        .o_resp       (resp),
        .o_resp_valid (resp_valid),
        .o_rd_start   (rd_start),
        .o_rd_addr    (rd_addr),
        .o_rd_stop    (rd_stop)
    );

    sd_read_streamer u_tx (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_sck_rise   (sck_rise),
        .i_sck_fall   (sck_fall),
        .i_csn        (csn_sync),
        .i_resp       (resp),
        .i_resp_valid (resp_valid),
        .i_rd_start   (rd_start),
        .i_rd_addr    (rd_addr),
        .i_rd_stop    (rd_stop),
        .o_miso       (o_miso)
    );

endmodule

`default_nettype wire

//--- src/sd_read_streamer.sv
`timescale 1ns/10ps
`default_nettype none
`include "sd_card_config.svh"

module sd_read_streamer (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_sck_rise,
    input  logic                  i_sck_fall,
    input  logic                  i_csn,
    input  sd_card_pkg::sd_resp_t i_resp,
    input  logic                  i_resp_valid,
    input  logic                  i_rd_start,
    input  sd_card_pkg::sd_arg_t  i_rd_addr,
    input  logic                  i_rd_stop,
    output logic                  o_miso
);
    import sd_card_pkg::*;

    localparam int CNT_W = $clog2(`SD_BLOCK_SIZE);

    sd_tx_state_e     tx_state;
    sd_tx_state_e     next_state;
    logic [2:0]       bit_cnt;      // falls per byte, rises while in gap
    logic [CNT_W-1:0] byte_cnt;
    logic [CNT_W-1:0] next_cnt;
    logic             reading;
    logic             miso_q;
    logic [7:0]       shift_q;
    logic [7:0]       next_byte;
    logic [7:0]       data_byte;
    logic [39:0]      resp_bytes;   // r1 then ocr, msb first
    logic             has_ocr;
    sd_arg_t          blk_addr;
    sd_crc16_t        crc;

    // ccitt 0x1021, data bits msb first
    function automatic sd_crc16_t crc16_byte(input sd_crc16_t crc_in, input logic [7:0] data);
        sd_crc16_t c;
        c = crc_in;
        for (int i = 7; i >= 0; i--) begin
            c = {c[14:0], 1'b0} ^ ((c[15] ^ data[i]) ? 16'h1021 : 16'h0000);
        end
        return c;
    endfunction

    assign data_byte = blk_addr[7:0] + 8'(byte_cnt);

    // byte to load at the next byte boundary
    always_comb begin
        next_byte  = 8'hFF;
        next_state = tx_state;
        next_cnt   = byte_cnt + 1'b1;
        case (tx_state)
            TX_RESP: begin
                next_byte = resp_bytes[39:32];
                if (!has_ocr || byte_cnt == CNT_W'(4)) begin
                    next_state = reading ? TX_DGAP : TX_IDLE;
                    next_cnt   = '0;
                end
            end
            TX_DGAP: begin
                if (byte_cnt == CNT_W'(`SD_GAP_BYTES - 1)) begin
                    next_state = TX_TOKEN;
                    next_cnt   = '0;
                end
            end
            TX_TOKEN: begin
                next_byte  = 8'hFE;
                next_state = TX_DATA;
                next_cnt   = '0;
            end
            TX_DATA: begin
                next_byte = data_byte;
                if (byte_cnt == CNT_W'(`SD_BLOCK_SIZE - 1)) begin
                    next_state = TX_CRC;
                    next_cnt   = '0;
                end
            end
            TX_CRC: begin
                next_byte = byte_cnt[0] ? crc[7:0] : crc[15:8];
                if (byte_cnt[0]) begin
                    next_state = reading ? TX_DGAP : TX_IDLE;
                    next_cnt   = '0;
                end
            end
            default: ;  // idle and gap send 0xff
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tx_state <= TX_IDLE;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            reading  <= 1'b0;
            miso_q   <= 1'b1;
        end else if (i_csn) begin
            tx_state <= TX_IDLE;
            bit_cnt  <= '0;
            reading  <= 1'b0;
            miso_q   <= 1'b1;
        end else if (i_resp_valid) begin
            // drop whatever byte is in flight, realign on the next fall
            tx_state <= TX_GAP;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            reading  <= i_rd_start | (reading & ~i_rd_stop);
        end else if (tx_state == TX_GAP) begin
            if (i_sck_fall) begin
                miso_q <= 1'b1;
            end
            if (i_sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    tx_state <= TX_RESP;
                end
            end
        end else if (i_sck_fall) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd0) begin
                miso_q   <= next_byte[7];
                tx_state <= next_state;
                byte_cnt <= next_cnt;
            end else begin
                miso_q <= shift_q[7];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_resp_valid) begin
            resp_bytes <= {i_resp.r1, i_resp.ocr};
            has_ocr    <= i_resp.has_ocr;
            if (i_rd_start) begin
                blk_addr <= i_rd_addr;
            end
        end else if (i_sck_fall && tx_state != TX_GAP) begin
            if (bit_cnt == 3'd0) begin
                shift_q <= {next_byte[6:0], 1'b1};
                case (tx_state)
                    TX_RESP:  resp_bytes <= {resp_bytes[31:0], 8'hFF};
                    TX_TOKEN: crc <= '0;
                    TX_DATA:  crc <= crc16_byte(crc, data_byte);
                    TX_CRC: begin
                        if (byte_cnt[0]) begin
                            blk_addr <= blk_addr + 32'd1;  // next block
                        end
                    end
                    default: ;
                endcase
            end else begin
                shift_q <= {shift_q[6:0], 1'b1};
            end
        end
    end

    assign o_miso = miso_q;

    // start address and stop are only taken together with a response
    a_rd_ctrl_with_resp: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_rd_start || i_rd_stop) |-> i_resp_valid);

endmodule

`default_nettype wire

//--- src/sd_card_fsm.sv
`timescale 1ns/10ps
`default_nettype none
`include "sd_card_config.svh"

module sd_card_fsm (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  sd_card_pkg::sd_cmd_t  i_cmd,
    input  logic                  i_cmd_valid,
    output sd_card_pkg::sd_resp_t o_resp,
    output logic                  o_resp_valid,
    output logic                  o_rd_start,
    output sd_card_pkg::sd_arg_t  o_rd_addr,
    output logic                  o_rd_stop
);
    import sd_card_pkg::*;

    sd_card_state_e state;
    sd_card_state_e state_n;
    logic           app_flag;   // last command was CMD55
    logic           app_n;
    logic           hcs;
    logic           hcs_n;
    logic           start_n;
    logic           stop_n;
    sd_r1_t         idle_r1;
    sd_resp_t       resp_n;
    sd_arg_t        rd_addr_n;

    assign idle_r1 = (state == SD_IDLE) ? R1_IDLE : R1_READY;

    // byte address for standard capacity, block number otherwise
    assign rd_addr_n = hcs ? i_cmd.arg : i_cmd.arg / `SD_BLOCK_SIZE;

    always_comb begin
        state_n = state;
        app_n   = app_flag;
        hcs_n   = hcs;
        start_n = 1'b0;
        stop_n  = 1'b0;
        resp_n  = '{r1: R1_ILLEGAL | idle_r1, ocr: '0, has_ocr: 1'b0};
        if (i_cmd_valid) begin
            app_n = 1'b0;
            case (i_cmd.index)
                CMD_GO_IDLE: begin
                    if (i_cmd.crc_ok) begin
                        state_n   = SD_IDLE;
                        stop_n    = (state == SD_DATA);
                        resp_n.r1 = R1_IDLE;
                    end else begin
                        resp_n.r1 = R1_CRC_ERR | idle_r1;
                    end
                end
                CMD_SEND_IF_COND: begin
                    resp_n.r1 = i_cmd.crc_ok ? idle_r1 : (R1_CRC_ERR | idle_r1);
                end
                CMD_APP_CMD: begin
                    app_n     = 1'b1;
                    resp_n.r1 = idle_r1;
                end
                ACMD_SEND_OP_COND: begin
                    resp_n.r1 = idle_r1;    // idle bit from before the transition
                    if (app_flag && state == SD_IDLE) begin
                        state_n = SD_READY;
                        hcs_n   = i_cmd.arg[30];
                    end
                end
                CMD_READ_OCR: begin
                    resp_n = '{
                        r1:      idle_r1,
                        ocr:     OCR_VDD | {state != SD_IDLE, hcs, 30'd0},
                        has_ocr: 1'b1
                    };
                end
                CMD_READ_MULTI: begin
                    if (state == SD_READY) begin
                        state_n   = SD_DATA;
                        start_n   = 1'b1;
                        resp_n.r1 = R1_READY;
                    end
                end
                CMD_STOP_TRAN: begin
                    if (state == SD_DATA) begin
                        state_n   = SD_READY;
                        stop_n    = 1'b1;
                        resp_n.r1 = R1_READY;
                    end
                end
                default: ;  // illegal command
            endcase
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= SD_UNKNOWN;
            app_flag     <= 1'b0;
            hcs          <= 1'b0;
            o_resp_valid <= 1'b0;
            o_rd_start   <= 1'b0;
            o_rd_stop    <= 1'b0;
        end else begin
            state        <= state_n;
            app_flag     <= app_n;
            hcs          <= hcs_n;
            o_resp_valid <= i_cmd_valid;
            o_rd_start   <= start_n;
            o_rd_stop    <= stop_n;
        end
    end

    always_ff @(posedge clk) begin
        if (i_cmd_valid) begin
            o_resp <= resp_n;
        end
        if (start_n) begin
            o_rd_addr <= rd_addr_n;
        end
    end

    // a held strobe would run the command twice
    a_cmd_strobe: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_cmd_valid |=> !i_cmd_valid);

endmodule

`default_nettype wire

//--- src/sd_cmd_receiver.sv
`timescale 1ns/10ps
`default_nettype none
`include "sd_card_config.svh"

module sd_cmd_receiver (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_sck_rise,
    input  logic                 i_csn,
    input  logic                 i_mosi,
    output sd_card_pkg::sd_cmd_t o_cmd,
    output logic                 o_cmd_valid
);
    import sd_card_pkg::*;

    localparam int CRC_BITS = `SD_CMD_BITS - 8;  // start, tx, index and argument

    sd_rx_state_e            rx_state;
    logic [`SD_CMD_BITS-1:0] frame;
    logic [5:0]              bit_cnt;
    logic                    last_bit;   // previous mosi while hunting
    sd_crc7_t                crc;

    // x^7 + x^3 + 1, one bit per call
    function automatic sd_crc7_t crc7_next(input sd_crc7_t c, input logic b);
        return {c[5:0], 1'b0} ^ ((c[6] ^ b) ? 7'h09 : 7'h00);
    endfunction

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_state <= RX_HUNT;
            bit_cnt  <= '0;
            last_bit <= 1'b1;
            crc      <= '0;
        end else if (i_csn) begin
            rx_state <= RX_HUNT;
            last_bit <= 1'b1;
        end else begin
            case (rx_state)
                RX_HUNT: begin
                    if (i_sck_rise) begin
                        last_bit <= i_mosi;
                        if (!last_bit && i_mosi) begin  // start bit then tx bit
                            rx_state <= RX_SHIFT;
                            bit_cnt  <= 6'd2;
                            crc      <= crc7_next(crc7_next('0, 1'b0), 1'b1);
                        end
                    end
                end
                RX_SHIFT: begin
                    if (i_sck_rise) begin
                        bit_cnt <= bit_cnt + 6'd1;
                        if (bit_cnt < CRC_BITS) begin
                            crc <= crc7_next(crc, i_mosi);
                        end
                        if (bit_cnt == 6'(`SD_CMD_BITS - 1)) begin
                            // a frame without its end bit is dropped
                            rx_state <= i_mosi ? RX_DONE : RX_HUNT;
                        end
                    end
                end
                default: rx_state <= RX_HUNT;   // done lasts one clk
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_sck_rise && !i_csn) begin
            frame <= {frame[`SD_CMD_BITS-2:0], i_mosi};
        end
    end

    assign o_cmd_valid = (rx_state == RX_DONE);
    assign o_cmd = '{
        index:  frame[45:40],
        arg:    frame[39:8],
        crc_ok: (frame[7:1] == crc)
    };

    // host keeps the card selected past the end bit
    a_cmd_selected: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_cmd_valid |-> !i_csn);

endmodule

`default_nettype wire

//--- src/sck_edge_detect.sv
`timescale 1ns/10ps
`default_nettype none

module sck_edge_detect (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_sck,
    input  logic i_csn,
    input  logic i_mosi,
    output logic o_sck_rise,
    output logic o_sck_fall,
    output logic o_csn,
    output logic o_mosi
);

    logic [2:0] sck_sync;   // bit 2 is the previous synchronized level
    logic [1:0] csn_sync;
    logic [1:0] mosi_sync;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sck_sync   <= '0;
            csn_sync   <= '1;
            mosi_sync  <= '1;
            o_sck_rise <= 1'b0;
            o_sck_fall <= 1'b0;
        end else begin
            sck_sync   <= {sck_sync[1:0], i_sck};
            csn_sync   <= {csn_sync[0], i_csn};
            mosi_sync  <= {mosi_sync[0], i_mosi};
            o_sck_rise <= sck_sync[1] & ~sck_sync[2];
            o_sck_fall <= ~sck_sync[1] & sck_sync[2];
        end
    end

    assign o_csn  = csn_sync[1];
    assign o_mosi = mosi_sync[1];

    // sck must stay high at least 4 clk, so no fall within 3 clk of a rise
    a_sck_level_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_sck_rise |-> !o_sck_fall [*4]);

endmodule

`default_nettype wire

//--- src/sd_card_pkg.sv
`default_nettype none

package sd_card_pkg;

    typedef logic [31:0] sd_arg_t;      // command argument or block number
    typedef logic [7:0]  sd_r1_t;
    typedef logic [6:0]  sd_crc7_t;
    typedef logic [15:0] sd_crc16_t;
    typedef logic [5:0]  sd_cmd_idx_t;

    localparam sd_cmd_idx_t CMD_GO_IDLE       = 6'd0;
    localparam sd_cmd_idx_t CMD_SEND_IF_COND  = 6'd8;
    localparam sd_cmd_idx_t CMD_STOP_TRAN     = 6'd12;
    localparam sd_cmd_idx_t CMD_READ_MULTI    = 6'd18;
    localparam sd_cmd_idx_t ACMD_SEND_OP_COND = 6'd41;
    localparam sd_cmd_idx_t CMD_APP_CMD       = 6'd55;
    localparam sd_cmd_idx_t CMD_READ_OCR      = 6'd58;

    // r1 status bits
    localparam sd_r1_t R1_READY   = 8'h00;
    localparam sd_r1_t R1_IDLE    = 8'h01;
    localparam sd_r1_t R1_ILLEGAL = 8'h04;
    localparam sd_r1_t R1_CRC_ERR = 8'h08;

    localparam sd_arg_t OCR_VDD = 32'h00FF8000;  // 2.7 to 3.6 V window

    typedef struct packed {
        sd_cmd_idx_t index;
        sd_arg_t     arg;
        logic        crc_ok;
    } sd_cmd_t;

    typedef struct packed {
        sd_r1_t  r1;
        sd_arg_t ocr;
        logic    has_ocr;   // R3 instead of R1
    } sd_resp_t;

    typedef enum logic [1:0] {
        SD_UNKNOWN,
        SD_IDLE,
        SD_READY,
        SD_DATA
    } sd_card_state_e;

    typedef enum logic [1:0] {
        RX_HUNT,
        RX_SHIFT,
        RX_DONE
    } sd_rx_state_e;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_GAP,
        TX_RESP,
        TX_DGAP,
        TX_TOKEN,
        TX_DATA,
        TX_CRC
    } sd_tx_state_e;

endpackage

`default_nettype wire

//--- include/sd_card_config.svh
`ifndef SD_CARD_CONFIG_SVH
`define SD_CARD_CONFIG_SVH

// bytes per read block
// 16 or 64 also work and keep simulation short
`define SD_BLOCK_SIZE 512

// start bit, tx bit, index, argument, crc7, end bit
`define SD_CMD_BITS 48

// 0xff bytes between response and token, and between blocks
`define SD_GAP_BYTES 2

`endif
